/* Bender.yml */
package:
  name: fnd_counter

sources:
  - counter_pkg.sv
  - cmd_parser.sv
  - btn_debounce.sv
  - count_core.sv
  - fnd_scan.sv
  - fnd_top.sv
  - target: simulation
    files:
      - tb_fnd_top.sv

/* btn_debounce.sv */
`timescale 1ns/1ps

module btn_debounce #(
    parameter int DB_DIV   = 100,
    parameter int DB_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic i_btn,
    output logic o_pulse
);

    localparam int DIV_W = (DB_DIV > 1) ? $clog2(DB_DIV) : 1;

    logic [DIV_W-1:0]    div_cnt;
    logic                sample_en;
    logic [DB_DEPTH-1:0] shift_q;
    logic                stable;
    logic                stable_q;

    // sample enable once every DB_DIV clocks
    assign sample_en = (div_cnt == DIV_W'(DB_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (sample_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // newest sample enters at the top
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q <= '0;
        end else if (sample_en) begin
            shift_q <= {i_btn, shift_q[DB_DEPTH-1:1]};
        end
    end

    // pressed only when every sample agrees
    assign stable = &shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_q <= 1'b0;
        end else begin
            stable_q <= stable;
        end
    end

    // rising edge of the filtered level
    assign o_pulse = stable & ~stable_q;

    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        o_pulse |=> !o_pulse);

endmodule

/* cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser (
    input  logic                     clk,
    input  logic                     rst,
    input  counter_pkg::cmd_byte_t   i_rx,
    output counter_pkg::ctrl_pulse_t o_cmd
);

    // one state per matched prefix
    typedef enum logic [3:0] {
        S_IDLE,
        S_R,
        S_RU,
        S_C,
        S_CL,
        S_CLE,
        S_CLEA,
        S_M,
        S_MO,
        S_MOD
    } state_e;

    state_e                   state_q;
    state_e                   state_d;
    counter_pkg::ctrl_pulse_t cmd_d;
    counter_pkg::ctrl_pulse_t cmd_q;
    logic [7:0]               ch;

    assign ch    = i_rx.data;
    assign o_cmd = cmd_q;

    always_comb begin
        state_d = state_q;
        cmd_d   = '0;
        // only valid bytes move the FSM
        if (i_rx.valid) begin
            // a mismatch drops back to idle, the byte is consumed
            state_d = S_IDLE;
            case (state_q)
                S_IDLE: begin
                    if (ch == "r") begin
                        state_d = S_R;
                    end else if (ch == "c") begin
                        state_d = S_C;
                    end else if (ch == "m") begin
                        state_d = S_M;
                    end
                end
                S_R:    if (ch == "u") state_d = S_RU;
                S_RU:   cmd_d.run_toggle = (ch == "n");
                S_C:    if (ch == "l") state_d = S_CL;
                S_CL:   if (ch == "e") state_d = S_CLE;
                S_CLE:  if (ch == "a") state_d = S_CLEA;
                S_CLEA: cmd_d.clear = (ch == "r");
                S_M:    if (ch == "o") state_d = S_MO;
                S_MO:   if (ch == "d") state_d = S_MOD;
                S_MOD:  cmd_d.mode_toggle = (ch == "e");
                default: state_d = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
            cmd_q   <= '0;
        end else begin
            state_q <= state_d;
            cmd_q   <= cmd_d;
        end
    end

    // commands are mutually exclusive on the output
    a_one_cmd: assert property (@(posedge clk) disable iff (rst)
        $onehot0(o_cmd));

endmodule

/* count_core.sv */
`timescale 1ns/1ps

module count_core #(
    parameter int TICK_DIV = 10_000_000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  counter_pkg::ctrl_pulse_t i_btn_pulse,
    input  counter_pkg::ctrl_pulse_t i_cmd_pulse,
    output counter_pkg::count_t      o_count
);

    localparam int RATE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    counter_pkg::ctrl_pulse_t req;
    logic                     run_q;
    logic                     down_q;
    logic [RATE_W-1:0]        rate_cnt;
    logic                     step;
    counter_pkg::count_t      count_q;

    // either source may request, same-cycle requests count once
    assign req = i_btn_pulse | i_cmd_pulse;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q  <= 1'b0;
            down_q <= 1'b0;
        end else begin
            if (req.run_toggle) begin
                run_q <= ~run_q;
            end
            if (req.mode_toggle) begin
                down_q <= ~down_q;
            end
        end
    end

    // step on the last clock of each rate period
    assign step = run_q && (rate_cnt == RATE_W'(TICK_DIV - 1));

    // held at zero while stopped or cleared
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rate_cnt <= '0;
        end else if (req.clear || !run_q || step) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    // clear takes priority over a step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (req.clear) begin
            count_q <= '0;
        end else if (step) begin
            if (!down_q) begin
                if (count_q == counter_pkg::count_t'(counter_pkg::COUNT_MAX)) begin
                    count_q <= '0;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end else begin
                if (count_q == '0) begin
                    count_q <= counter_pkg::count_t'(counter_pkg::COUNT_MAX);
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    assign o_count = count_q;

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        o_count <= counter_pkg::COUNT_MAX);

endmodule

/* counter_pkg.sv */
package counter_pkg;

    // counter range and display size
    localparam int COUNT_MAX  = 9999;
    localparam int NUM_DIGITS = 4;

    // 14 bits covers 0..9999
    typedef logic [13:0] count_t;

    // one decimal digit
    typedef logic [3:0] digit_t;

    // active-low segments, dp in bit 7
    typedef logic [7:0] seg_t;

    // one received character with its strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } cmd_byte_t;

    // single-cycle control requests
    typedef struct packed {
        logic run_toggle;
        logic clear;
        logic mode_toggle;
    } ctrl_pulse_t;

    // all segments off
    localparam seg_t SEG_BLANK = 8'hff;

    // digit 0..9 patterns, common anode
    localparam seg_t SEG_TABLE [10] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
        8'h92, 8'h82, 8'hf8, 8'h80, 8'h90
    };

endpackage

/* fnd_scan.sv */
`timescale 1ns/1ps

module fnd_scan #(
    parameter int SCAN_DIV = 100_000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  counter_pkg::count_t                 i_count,
    output logic [counter_pkg::NUM_DIGITS-1:0]  o_fnd_com,
    output counter_pkg::seg_t                   o_fnd_data
);

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int SEL_W  = $clog2(counter_pkg::NUM_DIGITS);

    logic [SCAN_W-1:0]   scan_cnt;
    logic                scan_en;
    logic [SEL_W-1:0]    sel_q;
    counter_pkg::count_t rest;
    counter_pkg::digit_t digits [counter_pkg::NUM_DIGITS];
    counter_pkg::digit_t cur_digit;

    // scan rate divider
    assign scan_en = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
        end else if (scan_en) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // units first, then tens, hundreds, thousands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_q <= '0;
        end else if (scan_en) begin
            sel_q <= sel_q + 1'b1;
        end
    end

    // split the count into decimal digits, least significant first
    always_comb begin
        rest = i_count;
        for (int i = 0; i < counter_pkg::NUM_DIGITS; i++) begin
            digits[i] = counter_pkg::digit_t'(rest % 10);
            rest      = rest / 10;
        end
    end

    assign cur_digit = digits[sel_q];

    // out-of-range digit shows blank
    always_comb begin
        if (cur_digit <= 4'd9) begin
            o_fnd_data = counter_pkg::SEG_TABLE[cur_digit];
        end else begin
            o_fnd_data = counter_pkg::SEG_BLANK;
        end
    end

    // one-cold digit enable
    assign o_fnd_com = ~(counter_pkg::NUM_DIGITS'(1) << sel_q);

    a_one_digit: assert property (@(posedge clk) disable iff (rst)
        $onehot(~o_fnd_com));

endmodule

/* fnd_top.sv */
`timescale 1ns/1ps

module fnd_top #(
    parameter int TICK_DIV = 10_000_000,
    parameter int SCAN_DIV = 100_000,
    parameter int DB_DIV   = 100,
    parameter int DB_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_btn_run,
    input  logic                                i_btn_clear,
    input  logic                                i_btn_mode,
    input  counter_pkg::cmd_byte_t              i_rx,
    output logic [counter_pkg::NUM_DIGITS-1:0]  o_fnd_com,
    output counter_pkg::seg_t                   o_fnd_data
);

    logic                     run_pulse;
    logic                     clear_pulse;
    logic                     mode_pulse;
    counter_pkg::ctrl_pulse_t btn_pulse;
    counter_pkg::ctrl_pulse_t cmd_pulse;
    counter_pkg::count_t      count;

    // button path
    btn_debounce #(.DB_DIV(DB_DIV), .DB_DEPTH(DB_DEPTH)) u_db_run (
        .clk     (clk),
        .rst     (rst),
        .i_btn   (i_btn_run),
        .o_pulse (run_pulse)
    );

    btn_debounce #(.DB_DIV(DB_DIV), .DB_DEPTH(DB_DEPTH)) u_db_clear (
        .clk     (clk),
        .rst     (rst),
        .i_btn   (i_btn_clear),
        .o_pulse (clear_pulse)
    );

    btn_debounce #(.DB_DIV(DB_DIV), .DB_DEPTH(DB_DEPTH)) u_db_mode (
        .clk     (clk),
        .rst     (rst),
        .i_btn   (i_btn_mode),
        .o_pulse (mode_pulse)
    );

    assign btn_pulse = '{run_toggle: run_pulse, clear: clear_pulse, mode_toggle: mode_pulse};

    // text command path
    cmd_parser u_cmd_parser (
        .clk   (clk),
        .rst   (rst),
        .i_rx  (i_rx),
        .o_cmd (cmd_pulse)
    );

    count_core #(.TICK_DIV(TICK_DIV)) u_count_core (
        .clk         (clk),
        .rst         (rst),
        .i_btn_pulse (btn_pulse),
        .i_cmd_pulse (cmd_pulse),
        .o_count     (count)
    );

    fnd_scan #(.SCAN_DIV(SCAN_DIV)) u_fnd_scan (
        .clk        (clk),
        .rst        (rst),
        .i_count    (count),
        .o_fnd_com  (o_fnd_com),
        .o_fnd_data (o_fnd_data)
    );

endmodule

/* sim.f */
counter_pkg.sv
cmd_parser.sv
btn_debounce.sv
count_core.sv
fnd_scan.sv
fnd_top.sv
tb_fnd_top.sv

/* tb_fnd_top.sv */
`timescale 1ns/1ps

module tb_fnd_top;

    localparam int CLK_PERIOD = 20;
    localparam int TICK_DIV   = 40;
    localparam int SCAN_DIV   = 2;
    localparam int DB_DIV     = 3;
    localparam int DB_DEPTH   = 4;

    localparam int HOLD      = (DB_DEPTH + 2) * DB_DIV;
    localparam int SETTLE    = 4;
    localparam int PRESS_CLK = HOLD + SETTLE;
    localparam int RUN_STEPS = 5;
    // 3 * 40 clocks is a multiple of DB_DIV, so both presses see the same sample phase
    localparam int BTN_STEPS = 3;
    localparam int MAX_K     = 6;
    localparam int ROUNDS    = 2;
    localparam int GAP       = 10;
    localparam int BTN_RUN   = 0;
    localparam int BTN_CLEAR = 1;
    localparam int BTN_MODE  = 2;

    // rough clock budget per test
    localparam int READ_CLK = 2 * counter_pkg::NUM_DIGITS * SCAN_DIV + 4;
    localparam int CMD_CLK  = 12;
    localparam int T_RESET  = 10 + READ_CLK;
    localparam int T_COUNT  = RUN_STEPS * TICK_DIV + 3 * CMD_CLK + 2 * READ_CLK;
    localparam int T_WRAP   = ROUNDS * (2 * MAX_K * TICK_DIV + 6 * CMD_CLK + 2 * READ_CLK);
    localparam int T_BTN    = 3 * BTN_STEPS * TICK_DIV + 7 * PRESS_CLK + 4 * READ_CLK;
    localparam int T_BAD    = (2 + 2 * RUN_STEPS) * TICK_DIV + GAP + 8 * CMD_CLK
                              + 3 * READ_CLK;
    localparam int TEST_CLOCKS = T_RESET + T_COUNT + T_WRAP + T_BTN + T_BAD;

    // mirror of the display encoding, digits 0..9
    localparam counter_pkg::seg_t SEG_PATTERNS [10] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
        8'h92, 8'h82, 8'hf8, 8'h80, 8'h90
    };

    // digit enables in scan order, units first
    localparam logic [3:0] COM_ORDER [4] = '{
        4'b1110, 4'b1101, 4'b1011, 4'b0111
    };

    logic                   clk;
    logic                   rst;
    logic                   i_btn_run;
    logic                   i_btn_clear;
    logic                   i_btn_mode;
    counter_pkg::cmd_byte_t i_rx;
    logic [3:0]             o_fnd_com;
    counter_pkg::seg_t      o_fnd_data;
    int unsigned            lcg_state = 7878;

    fnd_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV),
        .DB_DIV   (DB_DIV),
        .DB_DEPTH (DB_DEPTH)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_btn_run   (i_btn_run),
        .i_btn_clear (i_btn_clear),
        .i_btn_mode  (i_btn_mode),
        .i_rx        (i_rx),
        .o_fnd_com   (o_fnd_com),
        .o_fnd_data  (o_fnd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string test, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s: expected %0d, actual %0d", test, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // -1 for a pattern that is no digit
    function automatic int seg_to_digit(input counter_pkg::seg_t seg);
        for (int d = 0; d < 10; d++) begin
            if (SEG_PATTERNS[d] == seg) begin
                return d;
            end
        end
        return -1;
    endfunction

    task automatic step_clk();
        @(posedge clk);
        #2;
    endtask

    // one valid byte, then one idle cycle, per character
    task automatic send_cmd(input string text);
        for (int i = 0; i < text.len(); i++) begin
            i_rx.valid = 1'b1;
            i_rx.data  = text[i];
            step_clk();
            i_rx = '0;
            step_clk();
        end
    endtask

    task automatic hold_btn(input int which, input int cycles);
        case (which)
            BTN_RUN:   i_btn_run   = 1'b1;
            BTN_CLEAR: i_btn_clear = 1'b1;
            default:   i_btn_mode  = 1'b1;
        endcase
        repeat (cycles) step_clk();
        i_btn_run   = 1'b0;
        i_btn_clear = 1'b0;
        i_btn_mode  = 1'b0;
        repeat (SETTLE) step_clk();
    endtask

    task automatic press_btn(input int which);
        hold_btn(which, HOLD);
    endtask

    // walks one full scan starting at the units digit
    task automatic read_display(output int value);
        counter_pkg::digit_t digit;
        int                  code;
        int                  place;
        logic [3:0]          seen_com;
        value = 0;
        place = 1;
        repeat (2) step_clk();
        while (o_fnd_com != 4'b1110) begin
            step_clk();
        end
        for (int i = 0; i < counter_pkg::NUM_DIGITS; i++) begin
            if (!$onehot(~o_fnd_com)) begin
                report_failure("digit enable is not one-cold");
            end
            check_value("scan_order", COM_ORDER[i], o_fnd_com);
            code = seg_to_digit(o_fnd_data);
            if (code < 0) begin
                report_failure("segment pattern does not match any digit");
            end
            digit = counter_pkg::digit_t'(code);
            value = value + digit * place;
            place = place * 10;
            seen_com = o_fnd_com;
            while (o_fnd_com == seen_com) begin
                step_clk();
            end
        end
    endtask

    // final bytes of start and stop land steps * TICK_DIV clocks apart
    task automatic run_for(input string start, input int steps);
        send_cmd(start);
        repeat (steps * TICK_DIV - 6) step_clk();
        send_cmd("run");
    endtask

    task automatic test_reset();
        int shown;
        check_value("reset_com", 4'b1110, o_fnd_com);
        read_display(shown);
        check_value("reset_display", 0, shown);
    endtask

    task automatic test_run_clear();
        int shown;
        run_for("run", RUN_STEPS);
        read_display(shown);
        check_value("cmd_run", RUN_STEPS, shown);
        send_cmd("clear");
        read_display(shown);
        check_value("cmd_clear", 0, shown);
    endtask

    task automatic test_wrap();
        int k;
        int shown;
        for (int r = 0; r < ROUNDS; r++) begin
            k = 1 + int'(lcg_next() % MAX_K);
            send_cmd("mode");
            run_for("run", k);
            read_display(shown);
            check_value("wrap_down", 10000 - k, shown);
            send_cmd("mode");
            run_for("run", k);
            read_display(shown);
            check_value("wrap_up", 0, shown);
        end
    endtask

    task automatic test_buttons();
        int shown;
        press_btn(BTN_RUN);
        repeat (BTN_STEPS * TICK_DIV - PRESS_CLK) step_clk();
        press_btn(BTN_RUN);
        read_display(shown);
        check_value("btn_run", BTN_STEPS, shown);
        press_btn(BTN_CLEAR);
        read_display(shown);
        check_value("btn_clear", 0, shown);
        // long hold, still a single start
        hold_btn(BTN_RUN, 4 * HOLD);
        repeat (BTN_STEPS * TICK_DIV - 4 * HOLD - SETTLE) step_clk();
        press_btn(BTN_RUN);
        read_display(shown);
        check_value("btn_long_hold", BTN_STEPS, shown);
        // count back down to zero in down mode
        press_btn(BTN_MODE);
        press_btn(BTN_RUN);
        repeat (BTN_STEPS * TICK_DIV - PRESS_CLK) step_clk();
        press_btn(BTN_RUN);
        read_display(shown);
        check_value("btn_mode", 0, shown);
        press_btn(BTN_MODE);
    endtask

    task automatic test_bad_strings();
        int shown;
        run_for("run", RUN_STEPS);
        send_cmd("rux");
        send_cmd("cle");
        repeat (GAP) step_clk();
        send_cmd("m");
        // a stray start or clear would show by now
        repeat (2 * TICK_DIV) step_clk();
        read_display(shown);
        check_value("bad_strings", RUN_STEPS, shown);
        run_for("xrun", RUN_STEPS);
        read_display(shown);
        check_value("xrun_toggle", 2 * RUN_STEPS, shown);
        send_cmd("clear");
        read_display(shown);
        check_value("xrun_clear", 0, shown);
    endtask

    initial begin
        #(2 * TEST_CLOCKS * CLK_PERIOD);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        rst         = 1'b1;
        i_btn_run   = 1'b0;
        i_btn_clear = 1'b0;
        i_btn_mode  = 1'b0;
        i_rx        = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_run_clear();
        test_wrap();
        test_buttons();
        test_bad_strings();
        $display("All tests passed!");
        $finish;
    end

endmodule
